/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // Basic RV32I widths
    typedef logic [31:0] word_t;        // Data word or byte address
    typedef logic [4:0]  reg_idx_t;     // x0..x31
    typedef logic [3:0]  alu_op_t;      // {funct7[5], funct3} style code
    typedef logic [2:0]  op_class_t;    // Instruction class from decode
    typedef logic [2:0]  branch_cond_t; // Branch funct3

    // ALU operations
    // Low three bits follow funct3, bit 3 picks SUB and SRA
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_SRA  = 4'b1101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;

    // Instruction classes
    localparam op_class_t OPC_MEM    = 3'd0; // Load or store, address calc
    localparam op_class_t OPC_BRANCH = 3'd1; // Conditional branch
    localparam op_class_t OPC_ALU    = 3'd2; // Register or immediate ALU op
    localparam op_class_t OPC_JAL    = 3'd3;
    localparam op_class_t OPC_LUI    = 3'd4;
    localparam op_class_t OPC_AUIPC  = 3'd5;
    // Code 6 is unused and acts as a no-op class
    localparam op_class_t OPC_JALR   = 3'd7;

    // Branch conditions, same as B-type funct3
    localparam branch_cond_t BR_EQ  = 3'b000;
    localparam branch_cond_t BR_NE  = 3'b001;
    // 010 and 011 are reserved, never taken
    localparam branch_cond_t BR_LT  = 3'b100;
    localparam branch_cond_t BR_GE  = 3'b101;
    localparam branch_cond_t BR_LTU = 3'b110;
    localparam branch_cond_t BR_GEU = 3'b111;

    // Link value offset for JAL and JALR
    localparam word_t LINK_INC = 32'd4;

endpackage

/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded instruction as handed over by decode
    typedef struct packed {
        logic         valid;       // Low for a bubble
        word_t        pc;
        word_t        rs1_val;     // Register file read data
        word_t        rs2_val;
        word_t        imm;         // Sign-extended immediate
        op_class_t    op_class;
        logic         alu_src;     // ALU class only, picks imm over rs2
        alu_op_t      alu_op;      // ALU class only
        branch_cond_t branch_cond; // Branch class only
        logic         mem_read;
        logic         mem_write;
        logic         reg_write;
        logic         mem_to_reg;  // Writeback takes load data
        reg_idx_t     rd;
    } id_ex_t;

    // Result bundle toward the memory stage
    typedef struct packed {
        logic     valid;
        word_t    result;          // ALU result, address or link value
        word_t    store_data;      // rs2 for stores
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
    } ex_mem_t;

    // Fetch redirect
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* alu.sv */
module alu (
    input  rv_isa_pkg::word_t   a,
    input  rv_isa_pkg::word_t   b,
    input  rv_isa_pkg::alu_op_t op,
    output rv_isa_pkg::word_t   result,
    output logic                zero,   // a == b
    output logic                lt,     // Signed a < b
    output logic                ltu     // Unsigned a < b
);
    import rv_isa_pkg::*;

    logic [4:0] shamt; // RV32I shifts use only the low five bits
    word_t      sum;
    word_t      diff;

    assign shamt = b[4:0];
    assign sum   = a + b;
    assign diff  = a - b;

    // Flags are true compares, not taken from op
    assign zero = (a == b);
    assign lt   = ($signed(a) < $signed(b)); // No overflow issue as with sign of diff
    assign ltu  = (a < b);

    always_comb
    begin
        case (op)
            ALU_ADD:
            begin
                result = sum;
            end
            ALU_SUB:
            begin
                result = diff;
            end
            ALU_SLL:
            begin
                result = a << shamt;
            end
            ALU_SLT:
            begin
                result = {31'b0, lt};
            end
            ALU_SLTU:
            begin
                result = {31'b0, ltu};
            end
            ALU_XOR:
            begin
                result = a ^ b;
            end
            ALU_SRL:
            begin
                result = a >> shamt;
            end
            ALU_SRA:
            begin
                result = $signed(a) >>> shamt; // Sign fill from a[31]
            end
            ALU_OR:
            begin
                result = a | b;
            end
            ALU_AND:
            begin
                result = a & b;
            end
            default:
            begin
                result = sum; // Unused codes behave as ADD
            end
        endcase
    end

endmodule

/* branch_unit.sv */
module branch_unit (
    input  rv_pipe_pkg::id_ex_t    cur,
    input  logic                   zero,
    input  logic                   lt,
    input  logic                   ltu,
    output rv_pipe_pkg::redirect_t redirect
);
    import rv_isa_pkg::*;

    logic  is_jalr;
    logic  cond_met;    // Branch condition holds on the flags
    logic  class_taken; // Taken before valid gating
    word_t tgt_base;
    word_t tgt_sum;

    // Own target adder, ALU is busy with compare or link value
    assign is_jalr  = (cur.op_class == OPC_JALR);
    assign tgt_base = is_jalr ? cur.rs1_val : cur.pc;
    assign tgt_sum  = tgt_base + cur.imm;

    always_comb
    begin
        case (cur.branch_cond)
            BR_EQ:   cond_met = zero;
            BR_NE:   cond_met = ~zero;
            BR_LT:   cond_met = lt;
            BR_GE:   cond_met = ~lt;
            BR_LTU:  cond_met = ltu;
            BR_GEU:  cond_met = ~ltu;
            default: cond_met = 1'b0; // Reserved funct3 never branches
        endcase
    end

    always_comb
    begin
        case (cur.op_class)
            OPC_BRANCH:
            begin
                class_taken = cond_met;
            end
            OPC_JAL, OPC_JALR:
            begin
                class_taken = 1'b1; // Jumps always redirect
            end
            default:
            begin
                class_taken = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        redirect.taken  = cur.valid & class_taken; // Bubbles never redirect
        // JALR clears bit 0 of the sum
        redirect.target = is_jalr ? {tgt_sum[31:1], 1'b0} : tgt_sum;
    end

endmodule

/* execute_stage.sv */
module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::id_ex_t    id_bundle,  // From decode, sampled every cycle
    output rv_pipe_pkg::id_ex_t    cur,        // ID/EX register contents
    output rv_isa_pkg::word_t      alu_a,
    output rv_isa_pkg::word_t      alu_b,
    output rv_isa_pkg::alu_op_t    alu_op_sel
);
    import rv_isa_pkg::*;

    // ID/EX register
    // Everything is taken from here, operands and branch inputs alike
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cur <= '0; // Clears valid and all control bits
        end
        else
        begin
            cur <= id_bundle; // No stall, new slot each cycle
        end
    end

    // Operand and operation select by class
    always_comb
    begin
        alu_a      = '0;
        alu_b      = '0;
        alu_op_sel = ALU_ADD;
        case (cur.op_class)
            OPC_MEM:
            begin
                alu_a      = cur.rs1_val; // Effective address
                alu_b      = cur.imm;
                alu_op_sel = ALU_ADD;
            end
            OPC_BRANCH:
            begin
                alu_a      = cur.rs1_val;
                alu_b      = cur.rs2_val;
                alu_op_sel = ALU_SUB;     // Result unused, flags feed branch unit
            end
            OPC_ALU:
            begin
                alu_a      = cur.rs1_val;
                alu_b      = cur.alu_src ? cur.imm : cur.rs2_val; // I-type or R-type
                alu_op_sel = cur.alu_op;
            end
            OPC_LUI:
            begin
                alu_a      = '0;          // Passes imm through
                alu_b      = cur.imm;
                alu_op_sel = ALU_ADD;
            end
            OPC_AUIPC:
            begin
                alu_a      = cur.pc;
                alu_b      = cur.imm;
                alu_op_sel = ALU_ADD;
            end
            OPC_JAL, OPC_JALR:
            begin
                // Link value, target comes from branch unit
                alu_a      = cur.pc;
                alu_b      = LINK_INC;
                alu_op_sel = ALU_ADD;
            end
            default:
            begin
                alu_a      = '0;          // Undefined class gives zero
                alu_b      = '0;
                alu_op_sel = ALU_ADD;
            end
        endcase
    end

endmodule

/* ex_mem_reg.sv */
module ex_mem_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::id_ex_t    cur,
    input  rv_isa_pkg::word_t      result,
    input  rv_pipe_pkg::redirect_t redirect_in,
    output rv_pipe_pkg::ex_mem_t   ex_bundle,
    output rv_pipe_pkg::redirect_t redirect
);
    import rv_pipe_pkg::*;

    ex_mem_t ex_next;

    // Pack outgoing bundle
    always_comb
    begin
        ex_next.valid      = cur.valid;
        ex_next.result     = result;
        ex_next.store_data = cur.rs2_val;    // Stores write rs2
        ex_next.rd         = cur.rd;
        // Side effects only for a real instruction
        ex_next.reg_write  = cur.valid & cur.reg_write;
        ex_next.mem_read   = cur.valid & cur.mem_read;
        ex_next.mem_write  = cur.valid & cur.mem_write;
        ex_next.mem_to_reg = cur.valid & cur.mem_to_reg;
    end

    // EX/MEM register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_bundle <= '0;
            redirect  <= '0;  // No redirect out of reset
        end
        else
        begin
            ex_bundle <= ex_next;
            redirect  <= redirect_in; // Already gated by valid
        end
    end

endmodule

/* rv_execute.sv */
module rv_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::id_ex_t    id_bundle,
    output rv_pipe_pkg::ex_mem_t   ex_bundle,
    output rv_pipe_pkg::redirect_t redirect
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    id_ex_t    ex_cur;       // Registered bundle in EX
    word_t     alu_a;
    word_t     alu_b;
    alu_op_t   alu_op_sel;
    word_t     alu_result;
    logic      alu_zero;
    logic      alu_lt;
    logic      alu_ltu;
    redirect_t br_redirect;  // Combinational, registered in EX/MEM

    execute_stage i_execute_stage (
        .clk        (clk),
        .rst        (rst),
        .id_bundle  (id_bundle),
        .cur        (ex_cur),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op_sel (alu_op_sel)
    );

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op_sel),
        .result (alu_result),
        .zero   (alu_zero),
        .lt     (alu_lt),
        .ltu    (alu_ltu)
    );

    branch_unit i_branch_unit (
        .cur      (ex_cur),
        .zero     (alu_zero),
        .lt       (alu_lt),
        .ltu      (alu_ltu),
        .redirect (br_redirect)
    );

    ex_mem_reg i_ex_mem_reg (
        .clk         (clk),
        .rst         (rst),
        .cur         (ex_cur),
        .result      (alu_result),
        .redirect_in (br_redirect),
        .ex_bundle   (ex_bundle),
        .redirect    (redirect)
    );

endmodule

/* tb_rv_execute.sv */
module tb_rv_execute;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam word_t TB_SEED   = 32'h4db0251a;
    // Instructions driven per test
    localparam int N_RESET  = 24;
    localparam int N_ALU    = 600;
    localparam int N_MEM    = 200;
    localparam int N_BRANCH = 400;
    localparam int N_JUMP   = 120;
    localparam int N_PIPE   = 500;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_RESET + N_ALU + N_MEM + N_BRANCH
                                  + N_JUMP + N_PIPE + 6 * 3 + 100; // Drains plus margin

    // Expected outputs for one driven slot
    typedef struct packed {
        ex_mem_t   bundle;
        redirect_t redir;
        logic      check_tgt; // Target only defined for branches and jumps
    } expect_t;

    logic      clk;
    logic      rst;
    id_ex_t    id_bundle;
    ex_mem_t   ex_bundle;
    redirect_t redirect;

    expect_t exp_q[$];   // Oldest in flight at the front
    int      n_tests  = 0;
    int      n_checks = 0;
    int      n_errors = 0;
    int      cycle_count = 0;

    rv_execute i_rv_execute (
        .clk       (clk),
        .rst       (rst),
        .id_bundle (id_bundle),
        .ex_bundle (ex_bundle),
        .redirect  (redirect)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Edge values now and then, else fully random
    function automatic word_t rand_word();
        word_t pick;
        pick = $urandom;
        case (pick[3:0])
            4'd0:    return 32'h0000_0000;
            4'd1:    return 32'h8000_0000;
            4'd2:    return 32'hffff_ffff;
            4'd3:    return 32'h0000_001f; // Shift count 31
            4'd4:    return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic op_class_t rand_class();
        word_t pick;
        pick = $urandom;
        return pick[2:0]; // Includes the unused code 6
    endfunction

    function automatic alu_op_t pick_alu_op();
        case ($urandom_range(9, 0))
            0:       return ALU_ADD;
            1:       return ALU_SUB;
            2:       return ALU_SLL;
            3:       return ALU_SLT;
            4:       return ALU_SLTU;
            5:       return ALU_XOR;
            6:       return ALU_SRL;
            7:       return ALU_SRA;
            8:       return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic id_ex_t random_bundle(input op_class_t cls);
        id_ex_t b;
        word_t  ctl;
        word_t  pc_raw;
        ctl    = $urandom;
        pc_raw = $urandom;
        b.valid       = 1'b1;
        b.pc          = {pc_raw[31:2], 2'b00}; // Word aligned
        b.rs1_val     = rand_word();
        b.rs2_val     = rand_word();
        b.imm         = rand_word();
        b.op_class    = cls;
        b.alu_src     = ctl[0];
        b.alu_op      = pick_alu_op();
        b.branch_cond = ctl[3:1];
        b.mem_read    = ctl[4];
        b.mem_write   = ctl[5];
        b.reg_write   = ctl[6];
        b.mem_to_reg  = ctl[7];
        b.rd          = ctl[12:8];
        return b;
    endfunction

    // Reference ALU
    function automatic word_t model_alu(input alu_op_t op, input word_t x, input word_t y);
        case (op)
            ALU_ADD:  return x + y;
            ALU_SUB:  return x - y;
            ALU_SLL:  return x << y[4:0];
            ALU_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (x < y) ? 32'd1 : 32'd0;
            ALU_XOR:  return x ^ y;
            ALU_SRL:  return x >> y[4:0];
            ALU_SRA:  return $signed(x) >>> y[4:0];
            ALU_OR:   return x | y;
            default:  return x & y;
        endcase
    endfunction

    function automatic logic branch_holds(input branch_cond_t c, input word_t x, input word_t y);
        case (c)
            BR_EQ:   return x == y;
            BR_NE:   return x != y;
            BR_LT:   return $signed(x) < $signed(y);
            BR_GE:   return $signed(x) >= $signed(y);
            BR_LTU:  return x < y;
            BR_GEU:  return x >= y;
            default: return 1'b0; // Reserved codes
        endcase
    endfunction

    function automatic expect_t model_expect(input id_ex_t b);
        expect_t e;
        word_t   jalr_sum;
        e = '0;
        e.bundle.valid      = b.valid;
        e.bundle.store_data = b.rs2_val;
        e.bundle.rd         = b.rd;
        e.bundle.reg_write  = b.valid & b.reg_write;  // Bubble never writes
        e.bundle.mem_read   = b.valid & b.mem_read;
        e.bundle.mem_write  = b.valid & b.mem_write;
        e.bundle.mem_to_reg = b.valid & b.mem_to_reg;
        jalr_sum = b.rs1_val + b.imm;
        case (b.op_class)
            OPC_MEM:   e.bundle.result = b.rs1_val + b.imm;
            OPC_ALU:   e.bundle.result = model_alu(b.alu_op, b.rs1_val,
                                                   b.alu_src ? b.imm : b.rs2_val);
            OPC_LUI:   e.bundle.result = b.imm;
            OPC_AUIPC: e.bundle.result = b.pc + b.imm;
            OPC_BRANCH:
            begin
                e.bundle.result = b.rs1_val - b.rs2_val;
                e.redir.taken   = branch_holds(b.branch_cond, b.rs1_val, b.rs2_val);
                e.redir.target  = b.pc + b.imm;
                e.check_tgt     = 1'b1;
            end
            OPC_JAL:
            begin
                e.bundle.result = b.pc + 32'd4;  // Link value
                e.redir.taken   = 1'b1;
                e.redir.target  = b.pc + b.imm;
                e.check_tgt     = 1'b1;
            end
            OPC_JALR:
            begin
                e.bundle.result = b.pc + 32'd4;
                e.redir.taken   = 1'b1;
                e.redir.target  = {jalr_sum[31:1], 1'b0};
                e.check_tgt     = 1'b1;
            end
            default:   e.bundle.result = '0;
        endcase
        e.redir.taken = e.redir.taken & b.valid;
        return e;
    endfunction

    task automatic compare_outputs(input expect_t e);
        check_flag("ex_bundle.valid", ex_bundle.valid, e.bundle.valid);
        check_flag("ex_bundle.reg_write", ex_bundle.reg_write, e.bundle.reg_write);
        check_flag("ex_bundle.mem_read", ex_bundle.mem_read, e.bundle.mem_read);
        check_flag("ex_bundle.mem_write", ex_bundle.mem_write, e.bundle.mem_write);
        check_flag("ex_bundle.mem_to_reg", ex_bundle.mem_to_reg, e.bundle.mem_to_reg);
        check_flag("redirect.taken", redirect.taken, e.redir.taken);
        if (e.bundle.valid)
        begin
            check_word("ex_bundle.result", ex_bundle.result, e.bundle.result);
            check_word("ex_bundle.store_data", ex_bundle.store_data, e.bundle.store_data);
            check_reg("ex_bundle.rd", ex_bundle.rd, e.bundle.rd);
            if (e.check_tgt)
                check_word("redirect.target", redirect.target, e.redir.target);
        end
    endtask

    // One slot per falling edge, output of the slot two edges back is checked first
    task automatic drive_cycle(input id_ex_t b);
        @(negedge clk);
        if (exp_q.size() == 2)
            compare_outputs(exp_q.pop_front());
        id_bundle = b;
        exp_q.push_back(model_expect(b));
    endtask

    task automatic drain();
        while (exp_q.size() > 0)
        begin
            @(negedge clk);
            compare_outputs(exp_q.pop_front());
            id_bundle = '0;
        end
    endtask

    task automatic report_test(input string name, input int err0, input int chk0);
        n_tests++;
        $display("test %s: %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
    endtask

    task automatic run_tests();
        id_ex_t b;
        word_t  pick;
        int     err0;
        int     chk0;
        // Reset state, then bubbles carrying random payloads
        err0 = n_errors;
        chk0 = n_checks;
        check_flag("ex_bundle.valid", ex_bundle.valid, 1'b0);
        check_flag("ex_bundle.reg_write", ex_bundle.reg_write, 1'b0);
        check_flag("ex_bundle.mem_read", ex_bundle.mem_read, 1'b0);
        check_flag("ex_bundle.mem_write", ex_bundle.mem_write, 1'b0);
        check_flag("ex_bundle.mem_to_reg", ex_bundle.mem_to_reg, 1'b0);
        check_flag("redirect.taken", redirect.taken, 1'b0);
        for (int i = 0; i < N_RESET; i++)
        begin
            b = random_bundle(rand_class());
            b.valid = 1'b0;
            drive_cycle(b);
        end
        drain();
        report_test("reset_state", err0, chk0);

        err0 = n_errors;
        chk0 = n_checks;
        for (int i = 0; i < N_ALU; i++)
            drive_cycle(random_bundle(OPC_ALU));
        drain();
        report_test("alu_ops", err0, chk0);

        err0 = n_errors;
        chk0 = n_checks;
        for (int i = 0; i < N_MEM; i++)
        begin
            pick = $urandom;
            case (pick[1:0])
                2'd0:    drive_cycle(random_bundle(OPC_LUI));
                2'd1:    drive_cycle(random_bundle(OPC_AUIPC));
                default: drive_cycle(random_bundle(OPC_MEM));
            endcase
        end
        drain();
        report_test("mem_upper", err0, chk0);

        err0 = n_errors;
        chk0 = n_checks;
        for (int i = 0; i < N_BRANCH; i++)
        begin
            b = random_bundle(OPC_BRANCH);
            pick = $urandom;
            case (pick[1:0])
                2'd1: b.rs2_val = b.rs1_val;
                2'd2: b.rs2_val = b.rs1_val + {{31{pick[2]}}, 1'b1}; // Off by one
                2'd3:
                begin
                    // Opposite signs so signed and unsigned order disagree
                    b.rs1_val[31] = pick[2];
                    b.rs2_val[31] = ~pick[2];
                end
                default: ;
            endcase
            drive_cycle(b);
        end
        drain();
        report_test("branches", err0, chk0);

        err0 = n_errors;
        chk0 = n_checks;
        for (int i = 0; i < N_JUMP; i++)
        begin
            pick = $urandom;
            b = random_bundle(pick[0] ? OPC_JALR : OPC_JAL);
            if (pick[1])
                b.imm[0] = ~b.rs1_val[0]; // JALR sum with bit 0 set
            drive_cycle(b);
        end
        drain();
        report_test("jumps", err0, chk0);

        // Any class, about one slot in four a bubble
        err0 = n_errors;
        chk0 = n_checks;
        for (int i = 0; i < N_PIPE; i++)
        begin
            b = random_bundle(rand_class());
            pick = $urandom;
            b.valid = (pick[1:0] != 2'b00);
            drive_cycle(b);
        end
        drain();
        report_test("pipeline", err0, chk0);
    endtask

    initial
    begin
        void'($urandom(TB_SEED));
        rst       = 1'b1;
        id_bundle = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_tests();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* rv_execute.f */
rv_isa_pkg.sv
rv_pipe_pkg.sv
alu.sv
branch_unit.sv
execute_stage.sv
ex_mem_reg.sv
rv_execute.sv
tb_rv_execute.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rv_execute \
    -f rv_execute.f -Mdir obj_dir -o sim_rv_execute

./obj_dir/sim_rv_execute | tee sim.log

if grep -qx "All tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
